// ==== rtl/uart_pkg.sv ====
// UART peripheral shared definitions
// Widths, data types, register map, reset values, FSM state encodings

package uart_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////

  localparam int DATA_W     = 8;   // Character width
  localparam int FIFO_DEPTH = 16;  // Entries per FIFO
  localparam int PTR_W      = 4;   // FIFO pointer width
  localparam int CNT_W      = 5;   // Load 0..16
  localparam int BIT_W      = 3;   // Index of a data bit in a frame
  localparam int BDR_W      = 16;  // Bit period and sample phase
  localparam int ADR_W      = 6;   // Register offset
  localparam int WORD_W     = 32;  // Bus data

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [BDR_W-1:0]  bdr_t;
  typedef logic [ADR_W-1:0]  adr_t;
  typedef logic [WORD_W-1:0] word_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam adr_t ADR_TX_DAT = 6'h00;  // Write only, push
  localparam adr_t ADR_TX_CNT = 6'h04;  // Read only
  localparam adr_t ADR_TX_BDR = 6'h08;
  localparam adr_t ADR_TX_IRQ = 6'h10;
  localparam adr_t ADR_RX_DAT = 6'h20;  // Read pops
  localparam adr_t ADR_RX_CNT = 6'h24;
  localparam adr_t ADR_RX_BDR = 6'h28;
  localparam adr_t ADR_RX_SMP = 6'h2C;
  localparam adr_t ADR_RX_IRQ = 6'h30;

  localparam bdr_t BDR_RST = 16'd15;  // Sixteen cycles per bit
  localparam bdr_t SMP_RST = 16'd7;   // Mid-bit sample

  // FSM encodings
  typedef enum logic [1:0] {SER_IDLE, SER_START, SER_DATA, SER_STOP} ser_state_t;
  typedef enum logic [1:0] {DES_IDLE, DES_START, DES_DATA, DES_STOP} des_state_t;

endpackage : uart_pkg

// ==== rtl/uart_fifo.sv ====
// Synchronous character FIFO
// Valid/ready stream on both sides, occupancy count output

`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  // Input stream
  input  logic  sti_vld,
  input  data_t sti_dat,
  output logic  sti_rdy,
  // Output stream
  output logic  sto_vld,
  output data_t sto_dat,
  input  logic  sto_rdy,
  // Occupancy
  output cnt_t  cnt
);

  data_t            mem [FIFO_DEPTH];  // Storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push;
  logic             pop;

  assign push = sti_vld & sti_rdy;
  assign pop  = sto_vld & sto_rdy;

  // Full blocks input, empty blocks output
  assign sti_rdy = (cnt != CNT_W'(FIFO_DEPTH));
  assign sto_vld = (cnt != '0);
  assign sto_dat = mem[rd_ptr];  // Head entry

  //////////////////////////////
  // Pointers and load
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at 16
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop keeps the load
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // Storage write, no reset
  always_ff @(posedge tcb) begin
    if (push) mem[wr_ptr] <= sti_dat;
  end

endmodule : uart_fifo

// ==== rtl/uart_ser.sv ====
// UART transmit serializer
// Start bit, eight data bits LSB first, one stop bit

`timescale 1ns/1ps

module uart_ser import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  // Configuration
  input  bdr_t  cfg_bdr,  // Bit period minus one
  // Character stream
  input  logic  str_vld,
  input  data_t str_dat,
  output logic  str_rdy,
  // Serial line
  output logic  txd
);

  ser_state_t       state;
  bdr_t             bdr_cnt;  // Cycles left in current bit
  logic [BIT_W-1:0] bit_idx;  // Data bit index
  data_t            sft;      // Shift register
  logic             bit_end;

  assign str_rdy = (state == SER_IDLE);  // Accept only between frames
  assign bit_end = (bdr_cnt == '0);

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state   <= SER_IDLE;
      bdr_cnt <= '0;
      bit_idx <= '0;
      txd     <= 1'b1;  // Line idles high
    end else begin
      if (!bit_end) bdr_cnt <= bdr_cnt - 1'b1;
      case (state)
        SER_IDLE: begin
          txd <= 1'b1;
          if (str_vld) begin
            state   <= SER_START;
            txd     <= 1'b0;  // Start bit
            bdr_cnt <= cfg_bdr;
          end
        end
        SER_START: begin
          if (bit_end) begin
            state   <= SER_DATA;
            txd     <= sft[0];  // First data bit, LSB
            bdr_cnt <= cfg_bdr;
            bit_idx <= '0;
          end
        end
        SER_DATA: begin
          if (bit_end) begin
            bdr_cnt <= cfg_bdr;
            if (bit_idx == BIT_W'(DATA_W - 1)) begin
              state <= SER_STOP;
              txd   <= 1'b1;  // Stop bit
            end else begin
              txd     <= sft[1];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        SER_STOP: begin
          if (bit_end) state <= SER_IDLE;  // Next item one cycle later
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  // Payload shift, loaded on accept
  always_ff @(posedge tcb) begin
    if (str_vld && str_rdy) begin
      sft <= str_dat;
    end else if (bit_end && state == SER_DATA) begin
      sft <= sft >> 1;
    end
  end

endmodule : uart_ser

// ==== rtl/uart_des.sv ====
// UART receive deserializer
// Start edge detection, programmable sample phase, stop bit check

`timescale 1ns/1ps

module uart_des import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  // Configuration
  input  bdr_t  cfg_bdr,  // Bit period minus one
  input  bdr_t  cfg_smp,  // Sample phase from start edge
  // Serial line
  input  logic  rxd,
  // Character stream, no ready
  output logic  str_vld,
  output data_t str_dat
);

  logic [2:0]       rxd_sync;  // Two sync flops plus edge history
  logic             rxd_s;     // Synchronized line
  logic             rxd_fall;
  des_state_t       state;
  bdr_t             bdr_cnt;   // Cycles to next sample
  logic [BIT_W-1:0] bit_idx;
  data_t            sft;
  logic             smp_now;

  assign rxd_s    = rxd_sync[1];
  assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];
  assign smp_now  = (bdr_cnt == '0);
  assign str_dat  = sft;

  //////////////////////////////
  // Line synchronizer
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) rxd_sync <= '1;  // Idle high
    else        rxd_sync <= {rxd_sync[1:0], rxd};
  end

  //////////////////////////////
  // Sample FSM
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      state   <= DES_IDLE;
      bdr_cnt <= '0;
      bit_idx <= '0;
      str_vld <= 1'b0;
    end else begin
      str_vld <= 1'b0;  // Single-cycle push
      if (!smp_now) bdr_cnt <= bdr_cnt - 1'b1;
      case (state)
        DES_IDLE: begin
          if (rxd_fall) begin
            state   <= DES_START;
            bdr_cnt <= cfg_smp;
          end
        end
        DES_START: begin
          if (smp_now) begin
            // Glitch filter, low start sample required
            if (!rxd_s) begin
              state   <= DES_DATA;
              bdr_cnt <= cfg_bdr;
              bit_idx <= '0;
            end else begin
              state <= DES_IDLE;
            end
          end
        end
        DES_DATA: begin
          if (smp_now) begin
            bdr_cnt <= cfg_bdr;
            if (bit_idx == BIT_W'(DATA_W - 1)) state <= DES_STOP;
            else                               bit_idx <= bit_idx + 1'b1;
          end
        end
        DES_STOP: begin
          if (smp_now) begin
            state   <= DES_IDLE;
            str_vld <= rxd_s;  // Bad stop bit drops the character
          end
        end
        default: state <= DES_IDLE;
      endcase
    end
  end

  // Data bits enter at MSB, LSB arrives first
  always_ff @(posedge tcb) begin
    if (state == DES_DATA && smp_now) sft <= {rxd_s, sft[DATA_W-1:1]};
  end

endmodule : uart_des

// ==== rtl/uart_regs.sv ====
// UART register block
// Bus decode, configuration registers, FIFO push/pop steering, interrupts

`timescale 1ns/1ps

module uart_regs import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  // Register bus, always ready
  input  logic  bus_vld,
  input  logic  bus_wen,
  input  adr_t  bus_adr,
  input  word_t bus_wdt,
  output word_t bus_rdt,
  // TX FIFO side
  output logic  tx_vld,
  output data_t tx_dat,
  input  logic  tx_rdy,
  input  cnt_t  tx_cnt,
  output bdr_t  tx_bdr,
  // RX FIFO side
  input  logic  rx_vld,
  input  data_t rx_dat,
  output logic  rx_rdy,
  input  cnt_t  rx_cnt,
  output bdr_t  rx_bdr,
  output bdr_t  rx_smp,
  // Interrupts
  output logic  irq_tx,
  output logic  irq_rx
);

  cnt_t tx_irq;  // TX threshold
  cnt_t rx_irq;  // RX threshold
  logic bus_wr;
  logic bus_rd;

  assign bus_wr = bus_vld &  bus_wen;
  assign bus_rd = bus_vld & ~bus_wen;

  //////////////////////////////
  // Read decode
  //////////////////////////////

  always_comb begin
    case (bus_adr)
      ADR_TX_CNT: bus_rdt = WORD_W'(tx_cnt);
      ADR_TX_BDR: bus_rdt = WORD_W'(tx_bdr);
      ADR_TX_IRQ: bus_rdt = WORD_W'(tx_irq);
      // Empty RX FIFO reads zero
      ADR_RX_DAT: bus_rdt = rx_vld ? WORD_W'(rx_dat) : '0;
      ADR_RX_CNT: bus_rdt = WORD_W'(rx_cnt);
      ADR_RX_BDR: bus_rdt = WORD_W'(rx_bdr);
      ADR_RX_SMP: bus_rdt = WORD_W'(rx_smp);
      ADR_RX_IRQ: bus_rdt = WORD_W'(rx_irq);
      default:    bus_rdt = '0;  // TX data and holes
    endcase
  end

  // Pop only on a data read, FIFO ignores it when empty
  assign rx_rdy = bus_rd & (bus_adr == ADR_RX_DAT);

  //////////////////////////////
  // Write decode
  //////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      tx_bdr <= BDR_RST;
      tx_irq <= '0;
      rx_bdr <= BDR_RST;
      rx_smp <= SMP_RST;
      rx_irq <= '0;
    end else if (bus_wr) begin
      case (bus_adr)
        ADR_TX_BDR: tx_bdr <= bus_wdt[BDR_W-1:0];
        ADR_TX_IRQ: tx_irq <= bus_wdt[CNT_W-1:0];
        ADR_RX_BDR: rx_bdr <= bus_wdt[BDR_W-1:0];
        ADR_RX_SMP: rx_smp <= bus_wdt[BDR_W-1:0];
        ADR_RX_IRQ: rx_irq <= bus_wdt[CNT_W-1:0];
        default: ;  // Read-only or unmapped
      endcase
    end
  end

  // TX data write pushes straight into the FIFO
  assign tx_vld = bus_wr & (bus_adr == ADR_TX_DAT) & tx_rdy;  // Full FIFO drops it
  assign tx_dat = bus_wdt[DATA_W-1:0];

  //////////////////////////////
  // Interrupts
  //////////////////////////////

  assign irq_tx = (tx_cnt < tx_irq);  // TX running low
  assign irq_rx = (rx_cnt > rx_irq);  // RX filling up

endmodule : uart_regs

// ==== rtl/uart_top.sv ====
// UART peripheral top level
// Register block, TX and RX FIFOs, serializer, deserializer

`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  // Register bus
  input  logic  bus_vld,
  input  logic  bus_wen,
  input  adr_t  bus_adr,
  input  word_t bus_wdt,
  output word_t bus_rdt,
  // Serial lines
  input  logic  rxd,
  output logic  txd,
  // Interrupts
  output logic  irq_tx,
  output logic  irq_rx
);

  // Bus to TX FIFO
  logic  tx_bus_vld;
  data_t tx_bus_dat;
  logic  tx_bus_rdy;
  // TX FIFO to serializer
  logic  tx_str_vld;
  data_t tx_str_dat;
  logic  tx_str_rdy;
  // Deserializer to RX FIFO
  logic  rx_str_vld;
  data_t rx_str_dat;
  // RX FIFO to bus
  logic  rx_bus_vld;
  data_t rx_bus_dat;
  logic  rx_bus_rdy;
  // Status and configuration
  cnt_t  tx_cnt;
  cnt_t  rx_cnt;
  bdr_t  tx_bdr;
  bdr_t  rx_bdr;
  bdr_t  rx_smp;

  //////////////////////////////
  // Control
  //////////////////////////////

  uart_regs regs_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .bus_vld (bus_vld),
    .bus_wen (bus_wen),
    .bus_adr (bus_adr),
    .bus_wdt (bus_wdt),
    .bus_rdt (bus_rdt),
    .tx_vld  (tx_bus_vld),
    .tx_dat  (tx_bus_dat),
    .tx_rdy  (tx_bus_rdy),
    .tx_cnt  (tx_cnt),
    .tx_bdr  (tx_bdr),
    .rx_vld  (rx_bus_vld),
    .rx_dat  (rx_bus_dat),
    .rx_rdy  (rx_bus_rdy),
    .rx_cnt  (rx_cnt),
    .rx_bdr  (rx_bdr),
    .rx_smp  (rx_smp),
    .irq_tx  (irq_tx),
    .irq_rx  (irq_rx)
  );

  //////////////////////////////
  // TX path
  //////////////////////////////

  uart_fifo tx_fifo_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .sti_vld (tx_bus_vld),
    .sti_dat (tx_bus_dat),
    .sti_rdy (tx_bus_rdy),
    .sto_vld (tx_str_vld),
    .sto_dat (tx_str_dat),
    .sto_rdy (tx_str_rdy),
    .cnt     (tx_cnt)
  );

  uart_ser ser_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cfg_bdr (tx_bdr),
    .str_vld (tx_str_vld),
    .str_dat (tx_str_dat),
    .str_rdy (tx_str_rdy),
    .txd     (txd)
  );

  //////////////////////////////
  // RX path
  //////////////////////////////

  uart_des des_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cfg_bdr (rx_bdr),
    .cfg_smp (rx_smp),
    .rxd     (rxd),
    .str_vld (rx_str_vld),
    .str_dat (rx_str_dat)
  );

  uart_fifo rx_fifo_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .sti_vld (rx_str_vld),
    .sti_dat (rx_str_dat),
    .sti_rdy (),  // Deserializer never stalls, full FIFO drops
    .sto_vld (rx_bus_vld),
    .sto_dat (rx_bus_dat),
    .sto_rdy (rx_bus_rdy),
    .cnt     (rx_cnt)
  );

endmodule : uart_top

// ==== dv/uart_checker.sv ====
// UART bound assertions
// Serial line idle level, FIFO load bounds, interrupt rules

`timescale 1ns/1ps

module uart_checker import uart_pkg::*; (
  input logic       tcb,
  input logic       rst_n,
  input ser_state_t ser_state,  // Tied to idle where not bound to the serializer
  input logic       txd,
  input cnt_t       tx_cnt,
  input cnt_t       rx_cnt,
  input cnt_t       tx_irq,     // Thresholds
  input cnt_t       rx_irq,
  input logic       irq_tx,
  input logic       irq_rx
);

  // Line high between frames
  a_txd_idle: assert property (@(posedge tcb) disable iff (!rst_n)
    ser_state == SER_IDLE |-> txd)
    else $error("txd low while serializer idle");

  a_tx_cnt_max: assert property (@(posedge tcb) disable iff (!rst_n)
    tx_cnt <= CNT_W'(FIFO_DEPTH))
    else $error("TX load above FIFO depth");

  a_rx_cnt_max: assert property (@(posedge tcb) disable iff (!rst_n)
    rx_cnt <= CNT_W'(FIFO_DEPTH))
    else $error("RX load above FIFO depth");

  // Level interrupts
  a_irq_tx: assert property (@(posedge tcb) disable iff (!rst_n)
    irq_tx == (tx_cnt < tx_irq))
    else $error("irq_tx disagrees with TX threshold");

  a_irq_rx: assert property (@(posedge tcb) disable iff (!rst_n)
    irq_rx == (rx_cnt > rx_irq))
    else $error("irq_rx disagrees with RX threshold");

endmodule : uart_checker

// ==== dv/uart_monitor.sv ====
// UART monitor and scoreboard
// TX frame decoder, bus read compare, interrupt rules, error count

`timescale 1ns/1ps

module uart_monitor import uart_pkg::*; (
  input  logic  tcb,
  input  logic  rst_n,
  input  logic  bus_vld,
  input  logic  bus_wen,
  input  adr_t  bus_adr,
  input  word_t bus_rdt,
  input  logic  txd,
  input  logic  irq_tx,
  input  logic  irq_rx,
  // Model side
  input  logic  chk_en,   // Compare this read
  input  word_t chk_exp,
  input  logic  exp_vld,  // Byte accepted into TX FIFO
  input  data_t exp_dat,
  input  bdr_t  bdr,      // Model TX bit period
  input  cnt_t  tx_thr,
  input  cnt_t  rx_thr,
  output int    err_cnt,
  output int    tx_pend   // Frames not yet seen on txd
);

  data_t exp_q[$];

  initial err_cnt = 0;

  always @(posedge tcb) tx_pend = exp_q.size();

  //////////////////////////////
  // Bus side, mid-cycle
  //////////////////////////////

  always @(negedge tcb) begin
    if (exp_vld) exp_q.push_back(exp_dat);
    if (rst_n && bus_vld && !bus_wen) begin
      if (chk_en && bus_rdt !== chk_exp) begin
        $display("error bus_rdt adr %h exp %h got %h", bus_adr, chk_exp, bus_rdt);
        err_cnt++;
      end
      // Interrupts against the load just read
      if (bus_adr == ADR_TX_CNT && irq_tx !== (bus_rdt < WORD_W'(tx_thr))) begin
        $display("error irq_tx load %h thr %h got %h", bus_rdt, tx_thr, irq_tx);
        err_cnt++;
      end
      if (bus_adr == ADR_RX_CNT && irq_rx !== (bus_rdt > WORD_W'(rx_thr))) begin
        $display("error irq_rx load %h thr %h got %h", bus_rdt, rx_thr, irq_rx);
        err_cnt++;
      end
    end
  end

  //////////////////////////////
  // TX line decoder
  //////////////////////////////

  initial begin
    int    per;
    data_t got;
    data_t want;
    forever begin
      @(negedge tcb);
      if (rst_n && txd == 1'b0) begin
        per = int'(bdr) + 1;  // Cycles per bit
        repeat (per / 2) @(negedge tcb);  // Mid start bit
        if (txd !== 1'b0) begin
          $display("start bit on txd did not last half a bit period");
          err_cnt++;
        end
        for (int i = 0; i < DATA_W; i++) begin
          repeat (per) @(negedge tcb);
          got[i] = txd;  // LSB first
        end
        repeat (per) @(negedge tcb);
        if (txd !== 1'b1) begin
          $display("stop bit missing on txd");
          err_cnt++;
        end
        if (exp_q.size() == 0) begin
          $display("frame %h on txd with no byte written", got);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          if (got !== want) begin
            $display("error txd exp %h got %h", want, got);
            err_cnt++;
          end
        end
      end
    end
  end

endmodule : uart_monitor

// ==== dv/uart_tb.sv ====
// UART testbench top
// Clock, reset, LFSR stimulus, bus tasks, model queues, tests, timeout

`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

  localparam int N_BYTES = 20 + 18 + 8;                     // Bytes over all tests
  localparam int LIMIT   = N_BYTES * 10 * (200 + 1) * 2 + 2000;

  logic  tcb;
  logic  rst_n;
  logic  bus_vld;
  logic  bus_wen;
  adr_t  bus_adr;
  word_t bus_wdt;
  word_t bus_rdt;
  logic  txd;
  logic  irq_tx;
  logic  irq_rx;
  // Model and monitor control
  logic  chk_en;
  word_t chk_exp;
  logic  exp_vld;
  data_t exp_dat;
  bdr_t  m_tx_bdr;
  cnt_t  m_tx_thr;
  cnt_t  m_rx_thr;
  int    err_cnt;
  int    tx_pend;
  int    tb_err;
  int    err_mark;
  int    n_tests;
  int    cyc;
  logic [15:0] lfsr;
  data_t rx_q[$];  // Bytes expected back on RX data

  uart_top dut_i (
    .tcb(tcb), .rst_n(rst_n),
    .bus_vld(bus_vld), .bus_wen(bus_wen), .bus_adr(bus_adr), .bus_wdt(bus_wdt),
    .bus_rdt(bus_rdt),
    .rxd(txd), .txd(txd),  // Loopback
    .irq_tx(irq_tx), .irq_rx(irq_rx)
  );

  uart_monitor mon_i (
    .tcb(tcb), .rst_n(rst_n),
    .bus_vld(bus_vld), .bus_wen(bus_wen), .bus_adr(bus_adr), .bus_rdt(bus_rdt),
    .txd(txd), .irq_tx(irq_tx), .irq_rx(irq_rx),
    .chk_en(chk_en), .chk_exp(chk_exp), .exp_vld(exp_vld), .exp_dat(exp_dat),
    .bdr(m_tx_bdr), .tx_thr(m_tx_thr), .rx_thr(m_rx_thr),
    .err_cnt(err_cnt), .tx_pend(tx_pend)
  );

  bind uart_regs uart_checker chk_regs_i (
    .tcb(tcb), .rst_n(rst_n), .ser_state(SER_IDLE), .txd(1'b1),
    .tx_cnt(tx_cnt), .rx_cnt(rx_cnt), .tx_irq(tx_irq), .rx_irq(rx_irq),
    .irq_tx(irq_tx), .irq_rx(irq_rx)
  );

  bind uart_ser uart_checker chk_ser_i (
    .tcb(tcb), .rst_n(rst_n), .ser_state(state), .txd(txd),
    .tx_cnt('0), .rx_cnt('0), .tx_irq('0), .rx_irq('0),
    .irq_tx(1'b0), .irq_rx(1'b0)
  );

  initial begin
    tcb = 1'b0;
    forever #4 tcb = ~tcb;  // 8 ns period
  end

  // Run limit
  initial cyc = 0;
  always @(posedge tcb) begin
    cyc++;
    if (cyc >= LIMIT) begin
      $display("timeout after %0d cycles", cyc);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function word_t rand_bits(input int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[WORD_W-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge tcb);
      #1;
    end
  endtask

  task automatic bus_write(input adr_t adr, input word_t dat);
    bus_vld = 1'b1;
    bus_wen = 1'b1;
    bus_adr = adr;
    bus_wdt = dat;
    @(posedge tcb);
    #1;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    exp_vld = 1'b0;
    // Model follows the register after the edge
    case (adr)
      ADR_TX_BDR: m_tx_bdr = dat[BDR_W-1:0];
      ADR_TX_IRQ: m_tx_thr = dat[CNT_W-1:0];
      ADR_RX_IRQ: m_rx_thr = dat[CNT_W-1:0];
      default: ;
    endcase
  endtask

  task automatic bus_read(input adr_t adr, input word_t exp, input logic chk,
                          output word_t val);
    bus_vld = 1'b1;
    bus_wen = 1'b0;
    bus_adr = adr;
    chk_en  = chk;
    chk_exp = exp;
    #2;
    val = bus_rdt;  // Settled mid-cycle
    @(posedge tcb);
    #1;
    bus_vld = 1'b0;
    chk_en  = 1'b0;
  endtask

  // Keep marks a byte the TX FIFO will take
  task automatic send_byte(input data_t b, input logic keep);
    exp_vld = keep;
    exp_dat = b;
    if (keep) rx_q.push_back(b);
    bus_write(ADR_TX_DAT, WORD_W'(b));
  endtask

  task automatic set_line(input bdr_t bdr, input bdr_t smp);
    bus_write(ADR_TX_BDR, WORD_W'(bdr));
    bus_write(ADR_RX_BDR, WORD_W'(bdr));
    bus_write(ADR_RX_SMP, WORD_W'(smp));
  endtask

  // Pop n bytes as the RX load shows them
  task automatic collect(input int n);
    word_t v;
    int    got;
    got = 0;
    while (got < n) begin
      bus_read(ADR_RX_CNT, '0, 1'b0, v);
      if (v != '0) begin
        bus_read(ADR_RX_DAT, WORD_W'(rx_q.pop_front()), 1'b1, v);
        got++;
      end
    end
  endtask

  task automatic end_test(input string name);
    int e;
    idle(20);
    if (tx_pend != 0) begin
      $display("%0d written bytes never appeared on txd", tx_pend);
      tb_err++;
    end
    e = err_cnt + tb_err - err_mark;
    $display("test %-12s %s (%0d errors)", name, (e == 0) ? "ok" : "bad", e);
    err_mark = err_cnt + tb_err;
    n_tests++;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    word_t v;
    adr_t  cfg_adr[5];
    adr_t  hole_adr[3];
    int    m_cnt;
    int    lost;
    data_t b;
    rst_n   = 1'b0;
    bus_vld = 1'b0;
    bus_wen = 1'b0;
    bus_adr = '0;
    bus_wdt = '0;
    chk_en  = 1'b0;
    chk_exp = '0;
    exp_vld = 1'b0;
    exp_dat = '0;
    m_tx_bdr = BDR_RST;
    m_tx_thr = '0;
    m_rx_thr = '0;
    tb_err   = 0;
    err_mark = 0;
    n_tests  = 0;
    lfsr     = 16'd30263;
    cfg_adr  = '{ADR_TX_BDR, ADR_TX_IRQ, ADR_RX_BDR, ADR_RX_SMP, ADR_RX_IRQ};
    hole_adr = '{6'h0C, 6'h14, 6'h3C};
    repeat (2) @(posedge tcb);
    #1;
    rst_n = 1'b1;
    idle(2);

    // 1 Reset values, interrupts checked on the load reads
    bus_read(ADR_TX_BDR, WORD_W'(BDR_RST), 1'b1, v);
    bus_read(ADR_RX_BDR, WORD_W'(BDR_RST), 1'b1, v);
    bus_read(ADR_RX_SMP, WORD_W'(SMP_RST), 1'b1, v);
    bus_read(ADR_TX_CNT, '0, 1'b1, v);
    bus_read(ADR_RX_CNT, '0, 1'b1, v);
    bus_read(ADR_TX_IRQ, '0, 1'b1, v);
    bus_read(ADR_RX_IRQ, '0, 1'b1, v);
    end_test("reset");

    // 2 Readback masked to field width
    for (int r = 0; r < 4; r++) begin
      foreach (cfg_adr[i]) begin
        v = rand_bits(32);
        bus_write(cfg_adr[i], v);
        if (cfg_adr[i] == ADR_TX_IRQ || cfg_adr[i] == ADR_RX_IRQ)
          bus_read(cfg_adr[i], v & 32'h1F, 1'b1, v);
        else
          bus_read(cfg_adr[i], v & 32'hFFFF, 1'b1, v);
      end
      foreach (hole_adr[i]) begin
        bus_write(hole_adr[i], rand_bits(32));
        bus_read(hole_adr[i], '0, 1'b1, v);
      end
      bus_read(ADR_TX_DAT, '0, 1'b1, v);  // Write only
    end
    end_test("registers");

    // 3 Loopback in two batches that fit both FIFOs
    set_line(16'd7, 16'd3);
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 10; i++) send_byte(data_t'(rand_bits(8)), 1'b1);
      collect(10);
    end
    end_test("loopback");

    // 4 Back-pressure, serializer kept busy by a lead byte
    set_line(16'd200, 16'd100);
    send_byte(data_t'(rand_bits(8)), 1'b1);
    do bus_read(ADR_TX_CNT, '0, 1'b0, v); while (v != '0);
    m_cnt = 0;
    lost  = 0;
    for (int i = 0; i < 17; i++) begin
      b = data_t'(rand_bits(8));
      if (m_cnt < FIFO_DEPTH) begin
        send_byte(b, 1'b1);
        m_cnt++;
      end else begin
        send_byte(b, 1'b0);  // Meets a full FIFO
        lost++;
      end
    end
    bus_read(ADR_TX_CNT, WORD_W'(m_cnt), 1'b1, v);
    $display("back-pressure dropped %0d byte(s)", lost);
    collect(18 - lost);
    end_test("backpressure");

    // 5 Thresholds while draining and collecting
    set_line(16'd7, 16'd3);
    bus_write(ADR_TX_IRQ, rand_bits(5) % 17);
    bus_write(ADR_RX_IRQ, rand_bits(5) % 17);
    for (int i = 0; i < 8; i++) send_byte(data_t'(rand_bits(8)), 1'b1);
    do begin
      bus_read(ADR_TX_CNT, '0, 1'b0, v);
      bus_read(ADR_RX_CNT, '0, 1'b0, v);
    end while (v != 32'd8);
    collect(8);
    end_test("interrupts");

    $display("tests %0d, errors %0d", n_tests, err_cnt + tb_err);
    if (err_cnt + tb_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : uart_tb

// ==== flist.f ====
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_ser.sv
rtl/uart_des.sv
rtl/uart_regs.sv
rtl/uart_top.sv
dv/uart_checker.sv
dv/uart_monitor.sv
dv/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --assert \
  -f flist.f --top-module uart_tb -Mdir obj_dir -o uart_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
exit 1
